// File: verilog/acq_pkg.sv
// shared command word layout, field codes, widths and phase codes, used by scoped name only
`default_nettype none

package acq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // timing registers and the phase down-counter
  localparam int TIME_W   = 24;
  // run count and cycles-done counter
  localparam int CYCLE_W  = 16;
  // signal clock sum, N * S with room to spare
  localparam int SIGCLK_W = 40;

  ////////////////////////////////////////////////////////////////////////////
  // command word codes

  // top bit of every command word
  localparam logic OP_CONFIG = 1'b0;
  localparam logic OP_RUN    = 1'b1;

  // config word field select, other codes are acked and dropped
  localparam logic [1:0] SEL_PRECHARGE = 2'd0;
  localparam logic [1:0] SEL_SAMPLE    = 2'd1;

  // pre-charge switch levels
  // boot holds the signal behind the bootstrap while the mux moves
  localparam logic SW_PC_SIGNAL = 1'b1;
  localparam logic SW_PC_BOOT   = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer phase codes

  localparam logic [2:0] PH_IDLE      = 3'd0;
  localparam logic [2:0] PH_BOOT      = 3'd1;
  localparam logic [2:0] PH_PRECHARGE = 3'd2;
  localparam logic [2:0] PH_SIGNAL    = 3'd3;
  localparam logic [2:0] PH_REPROTECT = 3'd4;
  localparam logic [2:0] PH_LO        = 3'd5;

  ////////////////////////////////////////////////////////////////////////////
  // command word, one 32 bit word read through the view its opcode picks

  typedef union packed {
    // timing register write
    struct packed {
      logic              opcode;
      logic [1:0]        sel;
      logic [4:0]        rsvd;
      logic [TIME_W-1:0] value;
    } cfg;
    // run start with cycle count
    struct packed {
      logic               opcode;
      logic [14:0]        rsvd;
      logic [CYCLE_W-1:0] cycles;
    } run;
  } acq_cmd_u;

endpackage

`default_nettype wire

// File: verilog/acq_cmd_decode.sv
// host command port, takes four-phase req/ack words and keeps the timing and run-count registers
`default_nettype none
`timescale 1ns/1ps

module acq_cmd_decode (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          req_i,
  input  wire acq_pkg::acq_cmd_u       cmd_i,
  input  wire                          busy_i,
  output logic                         ack_o,
  output logic [acq_pkg::TIME_W-1:0]   precharge_cnt_o,
  output logic [acq_pkg::TIME_W-1:0]   sample_cnt_o,
  output logic [acq_pkg::CYCLE_W-1:0]  run_cycles_o,
  output logic                         start_o
);

  // registered copy of req
  // the word is taken the cycle after this goes high
  logic                        req_q;
  logic                        is_run;
  logic                        run_ok;
  logic                        accept;
  // config value with zero raised to one
  logic [acq_pkg::TIME_W-1:0]  cfg_value;

  ////////////////////////////////////////////////////////////////////////////
  // decode

  // opcode sits in the same bit for both views
  assign is_run = (cmd_i.cfg.opcode == acq_pkg::OP_RUN);

  // run words wait while the sequencer is busy
  assign run_ok = !busy_i;

  // new word only once the previous handshake has closed
  assign accept = req_q && !ack_o && (!is_run || run_ok);

  // a zero length phase would never end, so load one instead
  assign cfg_value = (cmd_i.cfg.value == '0) ?
                     {{(acq_pkg::TIME_W-1){1'b0}}, 1'b1} : cmd_i.cfg.value;

  ////////////////////////////////////////////////////////////////////////////
  // handshake and registers

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      req_q           <= 1'b0;
      ack_o           <= 1'b0;
      start_o         <= 1'b0;
      precharge_cnt_o <= {{(acq_pkg::TIME_W-1){1'b0}}, 1'b1};
      sample_cnt_o    <= {{(acq_pkg::TIME_W-1){1'b0}}, 1'b1};
      run_cycles_o    <= '0;
    end
    else
    begin
      req_q   <= req_i;
      // start is a single clock pulse
      start_o <= 1'b0;

      if (accept)
      begin
        ack_o <= 1'b1;
        if (is_run)
        begin
          // start goes out with the ack edge and carries the count
          run_cycles_o <= cmd_i.run.cycles;
          start_o      <= 1'b1;
        end
        else
        begin
          // config writes land at once and reach the sequencer
          // at its next phase load
          case (cmd_i.cfg.sel)
            acq_pkg::SEL_PRECHARGE:
              precharge_cnt_o <= cfg_value;
            acq_pkg::SEL_SAMPLE:
              sample_cnt_o <= cfg_value;
            default:
              // unknown select is only acked
              ;
          endcase
        end
      end
      else if (ack_o && !req_q)
      begin
        // host has let go of req so the handshake closes
        ack_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/acq_sequencer.sv
// acquisition phase sequencer, steps boot-protect then N cycles of pre-charge, signal, re-protect, lo
`default_nettype none
`timescale 1ns/1ps

module acq_sequencer (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          start_i,
  input  wire [acq_pkg::TIME_W-1:0]    precharge_cnt_i,
  input  wire [acq_pkg::TIME_W-1:0]    sample_cnt_i,
  input  wire [acq_pkg::CYCLE_W-1:0]   run_cycles_i,
  output logic                         busy_o,
  output logic                         sw_pc_ctl_o,
  output logic                         led0_o,
  output logic [7:0]                   monitor_o,
  output logic                         run_start_o,
  output logic                         cycle_end_o
);

  // only the pre-charge switch is driven here, the mux is left alone
  // so the signal sits behind boot whenever the az switch could inject charge

  logic [2:0]                  state;
  logic [2:0]                  next_state;
  // clocks left in the current phase, zero on its last clock
  logic [acq_pkg::TIME_W-1:0]  cnt;
  // cycles still to start
  logic [acq_pkg::CYCLE_W-1:0] cycles_left;
  logic                        phase_done;
  logic                        phase_entry;
  // reload values, phase of length L loads L-1
  logic [acq_pkg::TIME_W-1:0]  pc_load;
  logic [acq_pkg::TIME_W-1:0]  smp_load;

  assign phase_done  = (cnt == '0);
  assign phase_entry = (next_state != state);
  assign pc_load     = precharge_cnt_i - 1'b1;
  assign smp_load    = sample_cnt_i - 1'b1;

  // result stage hooks
  assign run_start_o = start_i && (state == acq_pkg::PH_IDLE);
  assign cycle_end_o = (state == acq_pkg::PH_LO) && phase_done;

  ////////////////////////////////////////////////////////////////////////////
  // next phase

  always_comb
  begin
    next_state = state;
    case (state)
      acq_pkg::PH_IDLE:
        if (start_i)
          next_state = acq_pkg::PH_BOOT;
      // boot and lo both either start another cycle or finish the run
      acq_pkg::PH_BOOT,
      acq_pkg::PH_LO:
        if (phase_done)
          next_state = (cycles_left == '0) ? acq_pkg::PH_IDLE : acq_pkg::PH_PRECHARGE;
      acq_pkg::PH_PRECHARGE:
        if (phase_done)
          next_state = acq_pkg::PH_SIGNAL;
      acq_pkg::PH_SIGNAL:
        if (phase_done)
          next_state = acq_pkg::PH_REPROTECT;
      acq_pkg::PH_REPROTECT:
        if (phase_done)
          next_state = acq_pkg::PH_LO;
      default:
        next_state = acq_pkg::PH_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // phase registers and outputs, all set on phase entry

  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      state       <= acq_pkg::PH_IDLE;
      cnt         <= '0;
      cycles_left <= '0;
      busy_o      <= 1'b0;
      sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
      led0_o      <= 1'b0;
      monitor_o   <= 8'h00;
    end
    else
    begin
      state <= next_state;
      if (phase_entry)
      begin
        case (next_state)
          // switch to boot first so the signal is protected from the outset
          acq_pkg::PH_BOOT:
          begin
            cnt         <= pc_load;
            cycles_left <= run_cycles_i;
            busy_o      <= 1'b1;
            sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
            led0_o      <= 1'b0;
            monitor_o   <= 8'h00;
          end
          // settle, mux would move to pc-out here, signal still on boot
          acq_pkg::PH_PRECHARGE:
          begin
            cnt         <= pc_load;
            cycles_left <= cycles_left - 1'b1;
            sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
            led0_o      <= 1'b0;
            monitor_o   <= 8'b0000_0001;
          end
          // hi measure, switch onto the signal
          acq_pkg::PH_SIGNAL:
          begin
            cnt         <= smp_load;
            sw_pc_ctl_o <= acq_pkg::SW_PC_SIGNAL;
            led0_o      <= 1'b1;
            monitor_o   <= 8'b0000_0011;
          end
          // back to boot before the mux leaves pc-out
          acq_pkg::PH_REPROTECT:
          begin
            cnt         <= pc_load;
            sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
            led0_o      <= 1'b0;
            monitor_o   <= 8'b0000_0001;
          end
          // lo measure
          acq_pkg::PH_LO:
          begin
            cnt         <= smp_load;
            sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
            led0_o      <= 1'b0;
            monitor_o   <= 8'h00;
          end
          // run over
          default:
          begin
            busy_o      <= 1'b0;
            sw_pc_ctl_o <= acq_pkg::SW_PC_BOOT;
            led0_o      <= 1'b0;
            monitor_o   <= 8'h00;
          end
        endcase
      end
      else if (state != acq_pkg::PH_IDLE)
      begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/acq_result_counter.sv
// run results, counts completed cycles and clocks with the switch on the signal, cleared per run
`default_nettype none
`timescale 1ns/1ps

module acq_result_counter (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           run_start_i,
  input  wire                           sw_pc_ctl_i,
  input  wire                           cycle_end_i,
  output logic [acq_pkg::CYCLE_W-1:0]   cycles_done_o,
  output logic [acq_pkg::SIGCLK_W-1:0]  signal_clocks_o
);

  // switch level decoded once
  logic on_signal;

  assign on_signal = (sw_pc_ctl_i == acq_pkg::SW_PC_SIGNAL);

  ////////////////////////////////////////////////////////////////////////////
  // cycle count

  // cycle_end marks the last lo clock, count shows up one clock later
  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      cycles_done_o <= '0;
    end
    else if (run_start_i)
    begin
      // fresh run, drop the old result
      cycles_done_o <= '0;
    end
    else if (cycle_end_i)
    begin
      cycles_done_o <= cycles_done_o + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // signal clock sum

  // switch level is registered in the sequencer,
  // so every clock it reads signal counts toward the hi integration
  always_ff @(posedge clk or posedge reset_n)
  begin
    if (reset_n)
    begin
      signal_clocks_o <= '0;
    end
    else if (run_start_i)
    begin
      signal_clocks_o <= '0;
    end
    else if (on_signal)
    begin
      signal_clocks_o <= signal_clocks_o + 1'b1;
    end
  end

  // both results hold after the run, until the next run start

endmodule

`default_nettype wire

// File: verilog/acq_frontend_top.sv
// acquisition front end top, wires the host decode, phase sequencer and result counter together
`default_nettype none
`timescale 1ns/1ps

module acq_frontend_top (
  input  wire                           clk,
  input  wire                           reset_n,
  input  wire                           req_i,
  input  wire acq_pkg::acq_cmd_u        cmd_i,
  output wire                           ack_o,
  output wire                           busy_o,
  output wire                           sw_pc_ctl_o,
  output wire                           led0_o,
  output wire [7:0]                     monitor_o,
  output wire [acq_pkg::CYCLE_W-1:0]    cycles_done_o,
  output wire [acq_pkg::SIGCLK_W-1:0]   signal_clocks_o
);

  // decode to sequencer
  wire [acq_pkg::TIME_W-1:0]  precharge_cnt;
  wire [acq_pkg::TIME_W-1:0]  sample_cnt;
  wire [acq_pkg::CYCLE_W-1:0] run_cycles;
  wire                        start;
  // sequencer to result counter
  wire                        run_start;
  wire                        cycle_end;

  acq_cmd_decode i_acq_cmd_decode (
    .clk             (clk),
    .reset_n         (reset_n),
    .req_i           (req_i),
    .cmd_i           (cmd_i),
    .busy_i          (busy_o),
    .ack_o           (ack_o),
    .precharge_cnt_o (precharge_cnt),
    .sample_cnt_o    (sample_cnt),
    .run_cycles_o    (run_cycles),
    .start_o         (start)
  );

  acq_sequencer i_acq_sequencer (
    .clk             (clk),
    .reset_n         (reset_n),
    .start_i         (start),
    .precharge_cnt_i (precharge_cnt),
    .sample_cnt_i    (sample_cnt),
    .run_cycles_i    (run_cycles),
    .busy_o          (busy_o),
    .sw_pc_ctl_o     (sw_pc_ctl_o),
    .led0_o          (led0_o),
    .monitor_o       (monitor_o),
    .run_start_o     (run_start),
    .cycle_end_o     (cycle_end)
  );

  acq_result_counter i_acq_result_counter (
    .clk             (clk),
    .reset_n         (reset_n),
    .run_start_i     (run_start),
    .sw_pc_ctl_i     (sw_pc_ctl_o),
    .cycle_end_i     (cycle_end),
    .cycles_done_o   (cycles_done_o),
    .signal_clocks_o (signal_clocks_o)
  );

endmodule

`default_nettype wire

// File: dv/acq_assert.sv
// bound checker for the host handshake and the switch phase rules, attached to the top level
`default_nettype none
`timescale 1ns/1ps

module acq_assert (
  input wire clk,
  input wire reset_n,
  input wire req_i,
  input wire ack_o,
  input wire busy_o,
  input wire sw_pc_ctl_o,
  input wire led0_o
);

  ////////////////////////////////////////////////////////////////////////////
  // host handshake

  // ack may only close after the host has let go of req
  ack_after_req: assert property (
    @(posedge clk) disable iff (reset_n)
    $fell(ack_o) |-> !$past(req_i)
  ) else $error("ack_o fell while req_i was still high");

  ////////////////////////////////////////////////////////////////////////////
  // switch phases

  // led marks the signal phase, so it needs the switch on the signal
  led_on_signal: assert property (
    @(posedge clk) disable iff (reset_n)
    led0_o |-> (sw_pc_ctl_o == acq_pkg::SW_PC_SIGNAL)
  ) else $error("led0_o high while the switch is on boot");

  // outside a run the signal stays behind boot
  signal_only_busy: assert property (
    @(posedge clk) disable iff (reset_n)
    (sw_pc_ctl_o == acq_pkg::SW_PC_SIGNAL) |-> busy_o
  ) else $error("switch on the signal while busy_o is low");

endmodule

bind acq_frontend_top acq_assert i_acq_assert (
  .clk         (clk),
  .reset_n     (reset_n),
  .req_i       (req_i),
  .ack_o       (ack_o),
  .busy_o      (busy_o),
  .sw_pc_ctl_o (sw_pc_ctl_o),
  .led0_o      (led0_o)
);

`default_nettype wire

// File: dv/acq_tb.sv
// directed testbench for the acquisition front end, compile with the file list and run acq_tb as top
`default_nettype none
`timescale 1ns/1ps

module acq_tb;

  logic                                clk;
  logic                                reset_n;
  logic                                req_i;
  acq_pkg::acq_cmd_u                   cmd_i;
  wire                                 ack_o;
  wire                                 busy_o;
  wire                                 sw_pc_ctl_o;
  wire                                 led0_o;
  wire [7:0]                           monitor_o;
  wire [acq_pkg::CYCLE_W-1:0]          cycles_done_o;
  wire [acq_pkg::SIGCLK_W-1:0]         signal_clocks_o;

  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  int          cycle_cnt = 0;
  // large until the run lengths are known
  int          cycle_limit = 1000000;
  logic [31:0] rng_state = 32'd46;
  // handshake bookkeeping from send_cmd and finish_run
  int          ack_cycle;
  logic        ack_busy;
  int          busy_fall_cycle;
  int          rnd_p [3];
  int          rnd_s [3];
  int          rnd_n [3];

  acq_frontend_top i_acq_frontend_top (
    .clk             (clk),
    .reset_n         (reset_n),
    .req_i           (req_i),
    .cmd_i           (cmd_i),
    .ack_o           (ack_o),
    .busy_o          (busy_o),
    .sw_pc_ctl_o     (sw_pc_ctl_o),
    .led0_o          (led0_o),
    .monitor_o       (monitor_o),
    .cycles_done_o   (cycles_done_o),
    .signal_clocks_o (signal_clocks_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cycle count doubles as the time base for handshake checks
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout, the runs did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int pick(input int lo, input int hi);
    logic [31:0] span;
    span = hi - lo + 1;
    return lo + int'(xorshift32() % span);
  endfunction

  // boot phase, then N cycles of P + S + P + S
  function automatic int run_len(input int p, input int s, input int n);
    return p + n * (2 * p + 2 * s);
  endfunction

  function automatic acq_pkg::acq_cmd_u cfg_word(input logic [1:0] sel, input int value);
    acq_pkg::acq_cmd_u w;
    w            = '0;
    w.cfg.opcode = acq_pkg::OP_CONFIG;
    w.cfg.sel    = sel;
    w.cfg.value  = value[acq_pkg::TIME_W-1:0];
    return w;
  endfunction

  function automatic acq_pkg::acq_cmd_u run_word(input int n);
    acq_pkg::acq_cmd_u w;
    w            = '0;
    w.run.opcode = acq_pkg::OP_RUN;
    w.run.cycles = n[acq_pkg::CYCLE_W-1:0];
    return w;
  endfunction

  task automatic compare_cycles(input string name, input logic [acq_pkg::CYCLE_W-1:0] got,
                                input logic [acq_pkg::CYCLE_W-1:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_sigclk(input string name, input logic [acq_pkg::SIGCLK_W-1:0] got,
                                input logic [acq_pkg::SIGCLK_W-1:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_monitor(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      mismatch_cnt++;
      $display("mismatch monitor_o: got 0x%0h, expected 0x%0h", got, exp);
    end
  endtask

  // four-phase write, returns with req dropped once ack is seen
  task automatic send_cmd(input acq_pkg::acq_cmd_u word);
    @(negedge clk);
    while (ack_o)
      @(negedge clk);
    cmd_i = word;
    req_i = 1'b1;
    @(negedge clk);
    while (!ack_o)
      @(negedge clk);
    ack_cycle = cycle_cnt;
    ack_busy  = busy_o;
    req_i     = 1'b0;
  endtask

  // follows one run from busy rise to busy fall against the phase table
  task automatic finish_run(input int p, input int s, input int n,
                            input bit check_phases, input bit check_sigclk);
    int                           t;
    int                           o;
    int                           period;
    longint                       prod;
    logic                         exp_sw;
    logic                         exp_led;
    logic [7:0]                   exp_mon;
    period = 2 * p + 2 * s;
    t      = 0;
    @(negedge clk);
    while (!busy_o)
      @(negedge clk);
    // run start has cleared the previous results
    compare_cycles("cycles_done_o at run start", cycles_done_o, '0);
    compare_sigclk("signal_clocks_o at run start", signal_clocks_o, '0);
    while (busy_o)
    begin
      if (check_phases)
      begin
        exp_sw  = acq_pkg::SW_PC_BOOT;
        exp_led = 1'b0;
        exp_mon = 8'h00;
        o       = (t - p) % period;
        if (t < p)
          exp_mon = 8'h00;
        else if (o < p)
          exp_mon = 8'h01;
        else if (o < p + s)
        begin
          exp_sw  = acq_pkg::SW_PC_SIGNAL;
          exp_led = 1'b1;
          exp_mon = 8'h03;
        end
        else if (o < 2 * p + s)
          exp_mon = 8'h01;
        compare_bit("sw_pc_ctl_o", sw_pc_ctl_o, exp_sw);
        compare_bit("led0_o", led0_o, exp_led);
        compare_monitor(monitor_o, exp_mon);
      end
      t++;
      @(negedge clk);
    end
    busy_fall_cycle = cycle_cnt;
    if (check_phases && t != run_len(p, s, n))
    begin
      mismatch_cnt++;
      $display("mismatch busy_o high clocks: got 0x%0h, expected 0x%0h", t, run_len(p, s, n));
    end
    compare_cycles("cycles_done_o", cycles_done_o, n[acq_pkg::CYCLE_W-1:0]);
    if (check_sigclk)
    begin
      prod = longint'(n) * longint'(s);
      compare_sigclk("signal_clocks_o", signal_clocks_o, prod[acq_pkg::SIGCLK_W-1:0]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_reset_values();
    @(negedge clk);
    compare_bit("ack_o", ack_o, 1'b0);
    compare_bit("busy_o", busy_o, 1'b0);
    compare_bit("led0_o", led0_o, 1'b0);
    compare_bit("sw_pc_ctl_o", sw_pc_ctl_o, acq_pkg::SW_PC_BOOT);
    compare_monitor(monitor_o, 8'h00);
    compare_cycles("cycles_done_o", cycles_done_o, '0);
    compare_sigclk("signal_clocks_o", signal_clocks_o, '0);
  endtask

  task automatic test_single_cycle();
    send_cmd(cfg_word(acq_pkg::SEL_PRECHARGE, 3));
    send_cmd(cfg_word(acq_pkg::SEL_SAMPLE, 5));
    send_cmd(run_word(1));
    finish_run(3, 5, 1, 1'b1, 1'b1);
  endtask

  task automatic test_random_runs();
    for (int i = 0; i < 3; i++)
    begin
      send_cmd(cfg_word(acq_pkg::SEL_PRECHARGE, rnd_p[i]));
      send_cmd(cfg_word(acq_pkg::SEL_SAMPLE, rnd_s[i]));
      send_cmd(run_word(rnd_n[i]));
      finish_run(rnd_p[i], rnd_s[i], rnd_n[i], 1'b1, 1'b1);
    end
  endtask

  // second run word is held off until the first run is over
  task automatic test_run_backpressure(input int p, input int s);
    send_cmd(run_word(2));
    fork
      finish_run(p, s, 2, 1'b1, 1'b1);
      begin
        repeat (3) @(negedge clk);
        send_cmd(run_word(3));
      end
    join
    if (ack_cycle <= busy_fall_cycle)
    begin
      fail_cnt++;
      $display("second run word was acknowledged before busy_o fell");
    end
    finish_run(p, s, 3, 1'b1, 1'b1);
  endtask

  // new sample length written mid run shows up in the following run
  task automatic test_config_during_run(input int p, input int s);
    send_cmd(run_word(2));
    fork
      finish_run(p, s, 2, 1'b0, 1'b0);
      begin
        repeat (p + 1) @(negedge clk);
        send_cmd(cfg_word(acq_pkg::SEL_SAMPLE, s + 3));
        if (!ack_busy)
        begin
          fail_cnt++;
          $display("config word was not acknowledged while the run was busy");
        end
      end
    join
    send_cmd(run_word(2));
    finish_run(p, s + 3, 2, 1'b1, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int p_last;
    int s_last;
    reset_n = 1'b1;
    req_i   = 1'b0;
    cmd_i   = '0;
    for (int i = 0; i < 3; i++)
    begin
      rnd_p[i] = pick(1, 20);
      rnd_s[i] = pick(1, 20);
      rnd_n[i] = pick(1, 5);
    end
    p_last = rnd_p[2];
    s_last = rnd_s[2];
    // every run once, the mid-run config run bounded by the longer sample
    cycle_limit = run_len(3, 5, 1) + run_len(rnd_p[0], rnd_s[0], rnd_n[0])
                + run_len(rnd_p[1], rnd_s[1], rnd_n[1]) + run_len(p_last, s_last, rnd_n[2])
                + run_len(p_last, s_last, 2) + run_len(p_last, s_last, 3)
                + 2 * run_len(p_last, s_last + 3, 2) + 200;

    repeat (4) @(negedge clk);
    reset_n = 1'b0;

    test_reset_values();
    test_single_cycle();
    test_random_runs();
    test_run_backpressure(p_last, s_last);
    test_config_during_run(p_last, s_last);

    repeat (2) @(negedge clk);
    $display("error count: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/acq_pkg.sv
verilog/acq_cmd_decode.sv
verilog/acq_sequencer.sv
verilog/acq_result_counter.sv
verilog/acq_frontend_top.sv
dv/acq_assert.sv
dv/acq_tb.sv

// File: Makefile
# Verilator build and run for the acquisition front end testbench

VERILATOR ?= verilator
TOP       ?= acq_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Test completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
